// File: Bender.yml
package:
  name: bulk_in_bridge

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/usb_bridge_pkg.sv
      - rtl/link_reset_ctrl.sv
      - rtl/telemetry_capture.sv
      - rtl/in_path_mux.sv
      - rtl/axis_skid.sv
      - rtl/bulk_in_bridge.sv
  - target: test
    files:
      - dv/bulk_in_bridge_tb.sv

// File: dv/bulk_in_bridge_tb.sv
`timescale 1ns/1ps

module bulk_in_bridge_tb;
  import usb_bridge_pkg::*;

  localparam int          CLK_HALF     = 20;
  localparam int          RESET_CYCLES = 8;
  localparam int          WD_FACTOR    = 4;   // Margin over the nominal budget
  localparam int          CMD_CYCLES   = 40;  // Nominal cycles per command
  localparam logic [31:0] SEED         = 32'h5a81c8ba;

  logic         clock;
  logic         areset_n;
  logic         usb_bus_reset_i;
  logic         ulpi_dir_i;
  logic         high_speed_i;
  logic         encode_idle_i;
  logic         decode_idle_i;
  link_status_t status_i;
  logic [3:0]   blk_endpt_i;
  logic         blk_in_ready_i;
  logic         s_valid_i;
  logic         s_ready_o;
  axis_byte_t   s_data_i;
  logic         m_valid_o;
  logic         m_ready_i;
  axis_byte_t   m_data_o;
  logic         reset_no;
  logic         usb_reset_o;
  logic         usb_idle_o;
  logic         blk_in_ready_o;
  logic         has_telemetry_o;

  string        cur_test = "none";
  axis_byte_t   send_q[$];         // User bytes not yet accepted
  axis_byte_t   exp_q[$];          // Bytes still due at m_*
  logic         rand_ready = 1'b0;
  string        lines[$];

  bulk_in_bridge uut (.*);

  initial begin
    clock = 1'b0;
    forever #(CLK_HALF) clock = ~clock;
  end

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("Errors found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic check_byte(input string what, input axis_byte_t exp, input axis_byte_t act);
    if (act !== exp) begin
      fail_now($sformatf("error %s: %s expected %h actual %h", cur_test, what, exp, act));
    end
  endtask

  task automatic check_level(input string what, input telem_level_t exp,
                             input telem_level_t act);
    if (act !== exp) begin
      fail_now($sformatf("error %s: %s expected %0d actual %0d", cur_test, what, exp, act));
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      fail_now($sformatf("error %s: %s expected %b actual %b", cur_test, what, exp, act));
    end
  endtask

  // Handshake on both streams with one decision per falling edge
  initial begin : stream_driver
    axis_byte_t seen;
    logic       in_fire;
    logic       out_fire;
    in_fire   = 1'b0;
    out_fire  = 1'b0;
    seen      = '0;
    s_valid_i = 1'b0;
    s_data_i  = '0;
    m_ready_i = 1'b1;
    void'($urandom(SEED));
    forever begin
      @(negedge clock);
      if (in_fire) begin
        void'(send_q.pop_front());
      end
      if (out_fire && exp_q.size() == 0) begin
        fail_now($sformatf("Output byte %h arrived in test %s with none expected",
                           seen, cur_test));
      end else if (out_fire) begin
        check_byte("m_data_o", exp_q.pop_front(), seen);
      end
      s_valid_i = (send_q.size() != 0);
      if (send_q.size() != 0) begin
        s_data_i = send_q[0];
      end
      m_ready_i = rand_ready ? ($urandom_range(1, 0) != 0) : 1'b1;
      #1;
      in_fire  = s_valid_i && s_ready_o;  // Transfers at the next rising edge
      out_fire = m_valid_o && m_ready_i;
      seen     = m_data_o;
    end
  end

  task automatic do_reset(input int phy_cyc, input int core_cyc);
    @(negedge clock);
    areset_n = 1'b0;
    repeat (RESET_CYCLES) @(negedge clock);
    check_flag("reset_no", 1'b0, reset_no);
    check_flag("usb_reset_o", 1'b1, usb_reset_o);
    check_flag("m_valid_o", 1'b0, m_valid_o);
    check_flag("has_telemetry_o", 1'b0, has_telemetry_o);
    check_flag("usb_idle_o", 1'b0, usb_idle_o);
    areset_n = 1'b1;
    for (int c = 1; c <= core_cyc + 1; c++) begin
      @(negedge clock);
      check_flag("reset_no", c >= phy_cyc, reset_no);
      check_flag("usb_reset_o", c < core_cyc, usb_reset_o);
    end
  endtask

  // Core reset follows the bus reset one cycle late on both edges
  task automatic bus_reset_pulse(input int len);
    @(negedge clock);
    check_flag("usb_reset_o", 1'b0, usb_reset_o);
    usb_bus_reset_i = 1'b1;
    for (int i = 1; i <= len + 1; i++) begin
      @(negedge clock);
      check_flag("usb_reset_o", i <= len, usb_reset_o);
      if (i == len) begin
        usb_bus_reset_i = 1'b0;
      end
    end
  endtask

  task automatic run_command(input string line);
    int         v[6];
    string      name;
    axis_byte_t b;
    case (line[0])
      "T": void'($sscanf(line, "T %s", cur_test));
      "R": begin
        void'($sscanf(line, "R %d %d", v[0], v[1]));
        do_reset(v[0], v[1]);
      end
      "B": begin
        void'($sscanf(line, "B %d", v[0]));
        bus_reset_pulse(v[0]);
      end
      "E": begin
        void'($sscanf(line, "E %d %d %d %d %d %d", v[0], v[1], v[2], v[3], v[4], v[5]));
        @(negedge clock);
        blk_endpt_i    = 4'(v[0]);
        blk_in_ready_i = v[1][0];
        ulpi_dir_i     = v[2][0];
        high_speed_i   = v[3][0];
        encode_idle_i  = v[4][0];
        decode_idle_i  = v[5][0];
      end
      "M": begin
        void'($sscanf(line, "M %d", v[0]));
        rand_ready = v[0][0];
      end
      "U": begin
        void'($sscanf(line, "U %h %d %d", v[0], v[1], v[2]));
        b.data = 8'(v[0]);
        b.keep = v[1][0];
        b.last = v[2][0];
        send_q.push_back(b);
        exp_q.push_back(b);  // Passes through untouched
      end
      "S": begin
        void'($sscanf(line, "S %h", v[0]));
        @(negedge clock);
        status_i = v[0][8:0];
      end
      "X": begin
        void'($sscanf(line, "X %h %h %h %h %d", v[0], v[1], v[2], v[3], v[4]));
        for (int k = 0; k < 4; k++) begin
          b.data = 8'(v[k]);
          b.keep = 1'b1;
          b.last = (k == 3) && v[4][0];  // Only the final byte of a record
          exp_q.push_back(b);
        end
      end
      "F": begin
        void'($sscanf(line, "F %s %d", name, v[0]));
        @(negedge clock);
        #2;
        case (name)
          "idle":    check_flag(name, v[0][0], usb_idle_o);
          "has_tel": check_flag(name, v[0][0], has_telemetry_o);
          "blk_rdy": check_flag(name, v[0][0], blk_in_ready_o);
          "s_ready": check_flag(name, v[0][0], s_ready_o);
          default:   fail_now({"Test data names an unknown flag: ", name});
        endcase
      end
      "L": begin
        void'($sscanf(line, "L %d", v[0]));
        @(negedge clock);
        #2;
        check_level("level", telem_level_t'(v[0]), uut.tel_level);
      end
      "W": begin
        void'($sscanf(line, "W %d", v[0]));
        repeat (v[0]) @(negedge clock);
      end
      "D": begin
        while (send_q.size() != 0 || exp_q.size() != 0) @(negedge clock);
      end
      default: fail_now({"Test data holds an unknown command: ", line});
    endcase
  endtask

  initial begin : main
    int    fd;
    int    limit;
    string line;
    areset_n        = 1'b0;  // Held until the first reset command
    usb_bus_reset_i = 1'b0;
    ulpi_dir_i      = 1'b0;
    high_speed_i    = 1'b1;  // Idle condition met during reset
    encode_idle_i   = 1'b1;
    decode_idle_i   = 1'b1;
    status_i        = '0;
    blk_endpt_i     = '0;
    blk_in_ready_i  = 1'b0;
    fd = $fopen("dv/bulk_in_bridge_testdata.txt", "r");
    if (fd == 0) begin
      fail_now("Could not open the test data file");
    end
    while (!$feof(fd)) begin
      if ($fgets(line, fd) > 0 && line[0] != "#" && line[0] != "\n") begin
        lines.push_back(line);
      end
    end
    $fclose(fd);
    limit = WD_FACTOR * lines.size() * CMD_CYCLES;
    fork
      begin : watchdog
        repeat (limit) @(posedge clock);
        fail_now($sformatf("Run did not finish within %0d cycles, stuck in test %s",
                           limit, cur_test));
      end
    join_none
    foreach (lines[i]) begin
      run_command(lines[i]);
    end
    $display("No errors");
    $finish;
  end

endmodule

// File: dv/bulk_in_bridge_testdata.txt
# T name | R phy core | B cycles | E ep blk_rdy dir hs enc dec | M rand_ready | W cycles | D
# U data keep last | S status | X b0 b1 b2 b3 last | F flag value | L level
T reset
R 2 4
B 3
T user_path
E 0 0 0 0 0 0
U 3c 1 0
U a5 1 0
U 00 0 0
U ff 1 1
D
T telem_records
E 2 0 0 0 0 0
F s_ready 0
S 0a5
X 00 a5 00 00 1
D
S 10c
X 01 0c 01 00 1
D
S 07f
S 07f
X 02 7f 00 00 1
D
W 3
L 0
T random_ready
M 1
E 0 0 0 0 0 0
U 11 1 0
U 22 0 0
U 33 1 1
U 44 1 0
D
E 2 0 0 0 0 0
S 011
S 022
X 03 11 00 00 0
X 04 22 00 00 1
D
M 0
T telem_packets
E 0 0 0 0 0 0
S 001
S 002
S 003
S 004
S 105
W 2
L 5
F blk_rdy 1
F has_tel 1
E 2 0 0 0 0 0
X 05 01 00 00 0
X 06 02 00 00 0
X 07 03 00 00 0
X 08 04 00 00 1
X 09 05 01 00 1
D
W 2
L 0
F has_tel 0
F blk_rdy 0
T idle_flag
E 0 0 0 1 1 1
F idle 1
E 0 0 1 1 1 1
F idle 0
E 0 0 0 1 1 0
F idle 0
E 0 1 0 1 1 1
F idle 1
F blk_rdy 1

// File: rtl/axis_skid.sv
`timescale 1ns/1ps

module axis_skid (
  input  logic                       clock,
  input  logic                       areset_n,
  input  logic                       core_rst_i,
  input  logic                       s_valid_i,
  output logic                       s_ready_o,
  input  usb_bridge_pkg::axis_byte_t s_data_i,
  output logic                       m_valid_o,
  input  logic                       m_ready_i,
  output usb_bridge_pkg::axis_byte_t m_data_o
);
  import usb_bridge_pkg::*;

  axis_byte_t out_q;   // Output register
  axis_byte_t skid_q;  // Catches a byte while the output stalls
  logic       out_valid_q;
  logic       skid_valid_q;
  logic       accept;
  logic       advance;

  assign accept  = s_valid_i && s_ready_o;
  assign advance = !out_valid_q || m_ready_i;  // Output register free next edge

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (core_rst_i) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (advance) begin
      out_valid_q  <= skid_valid_q || accept;
      skid_valid_q <= 1'b0;
    end else if (accept) begin
      skid_valid_q <= 1'b1;
    end
  end

  always_ff @(posedge clock) begin
    if (advance) begin
      if (skid_valid_q) begin
        out_q <= skid_q;     // Older byte first
      end else if (accept) begin
        out_q <= s_data_i;
      end
    end else if (accept) begin
      skid_q <= s_data_i;
    end
  end

  assign s_ready_o = !skid_valid_q;  // Drops only with both entries full
  assign m_valid_o = out_valid_q;
  assign m_data_o  = out_q;

  a_hold_data: assert property (
    @(posedge clock) disable iff (!areset_n || core_rst_i)
    (m_valid_o && !m_ready_i) |=> $stable(m_data_o)
  );

endmodule

// File: rtl/bulk_in_bridge.sv
`timescale 1ns/1ps

module bulk_in_bridge (
  input  logic                         clock,
  input  logic                         areset_n,
  input  logic                         usb_bus_reset_i,
  input  logic                         ulpi_dir_i,
  input  logic                         high_speed_i,
  input  logic                         encode_idle_i,
  input  logic                         decode_idle_i,
  input  usb_bridge_pkg::link_status_t status_i,
  input  logic [3:0]                   blk_endpt_i,
  input  logic                         blk_in_ready_i,
  input  logic                         s_valid_i,
  output logic                         s_ready_o,
  input  usb_bridge_pkg::axis_byte_t   s_data_i,
  output logic                         m_valid_o,
  input  logic                         m_ready_i,
  output usb_bridge_pkg::axis_byte_t   m_data_o,
  output logic                         reset_no,
  output logic                         usb_reset_o,
  output logic                         usb_idle_o,
  output logic                         blk_in_ready_o,
  output logic                         has_telemetry_o
);
  import usb_bridge_pkg::*;

  logic         core_rst;
  logic         tel_valid;
  logic         tel_ready;
  axis_byte_t   tel_data;
  telem_level_t tel_level;
  logic         mux_valid;
  logic         mux_ready;
  axis_byte_t   mux_data;

  link_reset_ctrl u_reset (
    .clock           (clock),
    .areset_n        (areset_n),
    .usb_bus_reset_i (usb_bus_reset_i),
    .ulpi_dir_i      (ulpi_dir_i),
    .high_speed_i    (high_speed_i),
    .encode_idle_i   (encode_idle_i),
    .decode_idle_i   (decode_idle_i),
    .reset_no        (reset_no),
    .core_rst_o      (core_rst),
    .idle_o          (usb_idle_o)
  );

  assign usb_reset_o = core_rst;

  telemetry_capture u_telem (
    .clock      (clock),
    .areset_n   (areset_n),
    .core_rst_i (core_rst),
    .status_i   (status_i),
    .t_valid_o  (tel_valid),
    .t_ready_i  (tel_ready),
    .t_data_o   (tel_data),
    .level_o    (tel_level)
  );

  // User bulk-IN or telemetry, picked by the served endpoint
  in_path_mux u_mux (
    .clock           (clock),
    .areset_n        (areset_n),
    .core_rst_i      (core_rst),
    .blk_endpt_i     (blk_endpt_i),
    .blk_in_ready_i  (blk_in_ready_i),
    .level_i         (tel_level),
    .s_valid_i       (s_valid_i),
    .s_ready_o       (s_ready_o),
    .s_data_i        (s_data_i),
    .t_valid_i       (tel_valid),
    .t_ready_o       (tel_ready),
    .t_data_i        (tel_data),
    .o_valid_o       (mux_valid),
    .o_ready_i       (mux_ready),
    .o_data_o        (mux_data),
    .blk_in_ready_o  (blk_in_ready_o),
    .has_telemetry_o (has_telemetry_o)
  );

  axis_skid u_skid (
    .clock      (clock),
    .areset_n   (areset_n),
    .core_rst_i (core_rst),
    .s_valid_i  (mux_valid),
    .s_ready_o  (mux_ready),
    .s_data_i   (mux_data),
    .m_valid_o  (m_valid_o),
    .m_ready_i  (m_ready_i),
    .m_data_o   (m_data_o)
  );

endmodule

// File: rtl/in_path_mux.sv
`timescale 1ns/1ps
`include "usb_bridge_macros.svh"

module in_path_mux (
  input  logic                         clock,
  input  logic                         areset_n,
  input  logic                         core_rst_i,
  input  logic [3:0]                   blk_endpt_i,
  input  logic                         blk_in_ready_i,
  input  usb_bridge_pkg::telem_level_t level_i,
  input  logic                         s_valid_i,
  output logic                         s_ready_o,
  input  usb_bridge_pkg::axis_byte_t   s_data_i,
  input  logic                         t_valid_i,
  output logic                         t_ready_o,
  input  usb_bridge_pkg::axis_byte_t   t_data_i,
  output logic                         o_valid_o,
  input  logic                         o_ready_i,
  output usb_bridge_pkg::axis_byte_t   o_data_o,
  output logic                         blk_in_ready_o,
  output logic                         has_telemetry_o
);
  import usb_bridge_pkg::*;

  localparam logic [3:0]   TELE_EP  = 4'(`TELEM_ENDPT);
  localparam telem_level_t PKT_RECS = telem_level_t'(`TELEM_PKT_RECS);

  logic tele_sel_q;  // Transactor is serving the telemetry endpoint
  logic blk_rdy_q;

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      tele_sel_q <= 1'b0;
      blk_rdy_q  <= 1'b0;
    end else if (core_rst_i) begin
      tele_sel_q <= 1'b0;
      blk_rdy_q  <= 1'b0;
    end else begin
      tele_sel_q <= (blk_endpt_i == TELE_EP);
      // A full packet of telemetry is ready even if the user side is not
      blk_rdy_q  <= blk_in_ready_i || (level_i >= PKT_RECS);
    end
  end

  assign o_valid_o = tele_sel_q ? t_valid_i : s_valid_i;
  assign o_data_o  = tele_sel_q ? t_data_i : s_data_i;
  assign s_ready_o = ~tele_sel_q & o_ready_i;
  assign t_ready_o = tele_sel_q & o_ready_i;

  assign blk_in_ready_o  = blk_rdy_q;
  assign has_telemetry_o = (level_i != '0);

  a_one_ready: assert property (
    @(posedge clock) disable iff (!areset_n)
    !(s_ready_o && t_ready_o)
  );

endmodule

// File: rtl/link_reset_ctrl.sv
`timescale 1ns/1ps
`include "usb_bridge_macros.svh"

module link_reset_ctrl (
  input  logic clock,
  input  logic areset_n,
  input  logic usb_bus_reset_i,
  input  logic ulpi_dir_i,
  input  logic high_speed_i,
  input  logic encode_idle_i,
  input  logic decode_idle_i,
  output logic reset_no,
  output logic core_rst_o,
  output logic idle_o
);

  logic [`RESET_STAGES-1:0] rel_q;  // Release token chain
  logic [`RESET_STAGES-1:0] rel_d;
  logic                     idle_q;

  always_comb begin
    rel_d = {rel_q[`RESET_STAGES-2:0], 1'b1};
    // A bus reset pulls the final stage back, the PHY reset stays released
    rel_d[`RESET_STAGES-1] = rel_q[`RESET_STAGES-2] & ~usb_bus_reset_i;
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      rel_q <= '0;
    end else begin
      rel_q <= rel_d;
    end
  end

  // Link idle only when the PHY does not drive and both codecs rest
  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      idle_q <= 1'b0;
    end else begin
      idle_q <= ~ulpi_dir_i & high_speed_i & encode_idle_i & decode_idle_i;
    end
  end

  assign reset_no   = rel_q[1];                     // PHY out of reset first
  assign core_rst_o = ~rel_q[`RESET_STAGES-1];
  assign idle_o     = idle_q;

  // The cores must never run while the PHY is still held
  a_core_after_phy: assert property (
    @(posedge clock) disable iff (!areset_n)
    !reset_no |-> core_rst_o
  );

endmodule

// File: rtl/telemetry_capture.sv
`timescale 1ns/1ps
`include "usb_bridge_macros.svh"

module telemetry_capture (
  input  logic                         clock,
  input  logic                         areset_n,
  input  logic                         core_rst_i,
  input  usb_bridge_pkg::link_status_t status_i,
  output logic                         t_valid_o,
  input  logic                         t_ready_i,
  output usb_bridge_pkg::axis_byte_t   t_data_o,
  output usb_bridge_pkg::telem_level_t level_o
);
  import usb_bridge_pkg::*;

  localparam int unsigned PTR_W = $clog2(`TELEM_DEPTH);
  localparam int unsigned PKT_W = $clog2(`TELEM_PKT_RECS);
  localparam logic [PKT_W-1:0] PKT_END = PKT_W'(`TELEM_PKT_RECS - 1);
  localparam telem_level_t FULL_LEVEL = telem_level_t'(`TELEM_DEPTH);
  localparam telem_level_t ONE_LEVEL  = telem_level_t'(1);

  telem_rec_u queue [`TELEM_DEPTH];  // Circular record store

  link_status_t      last_q;      // Last captured status
  logic [7:0]        seq_q;
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  telem_level_t      level_q;
  logic [1:0]        byte_idx_q;  // Byte of the head record on the stream
  logic [PKT_W-1:0]  pkt_cnt_q;   // Records already sent in this packet
  logic              end_q;       // Head record closes its packet

  telem_rec_u        new_rec;
  telem_rec_u        head_rec;
  logic              change;
  logic              push;
  logic              xfer;
  logic              pop;

  assign change = (status_i != last_q);
  assign push   = change && (level_q != FULL_LEVEL) && !core_rst_i;  // Full queue drops it
  assign xfer   = t_valid_o && t_ready_i;
  assign pop    = xfer && (byte_idx_q == 2'd3);

  always_comb begin
    new_rec = '0;
    new_rec.fields.status = status_i;
    new_rec.fields.seq    = seq_q;
  end

  always_ff @(posedge clock) begin
    if (push) begin
      queue[wr_ptr_q] <= new_rec;
    end
  end

  always_ff @(posedge clock or negedge areset_n) begin
    if (!areset_n) begin
      last_q     <= '0;
      seq_q      <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      level_q    <= '0;
      byte_idx_q <= '0;
      pkt_cnt_q  <= '0;
      end_q      <= 1'b0;
    end else if (core_rst_i) begin
      last_q     <= '0;
      seq_q      <= '0;
      wr_ptr_q   <= '0;
      rd_ptr_q   <= '0;
      level_q    <= '0;
      byte_idx_q <= '0;
      pkt_cnt_q  <= '0;
      end_q      <= 1'b0;
    end else begin
      last_q <= status_i;  // Dropped changes still count as seen
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
        seq_q    <= seq_q + 8'd1;
      end

      if (xfer) begin
        byte_idx_q <= byte_idx_q + 2'd1;
        // Decide tlast before the final byte shows, so it holds while stalled
        if (byte_idx_q == 2'd2) begin
          end_q <= (pkt_cnt_q == PKT_END) || ((level_q == ONE_LEVEL) && !push);
        end
      end

      if (pop) begin
        rd_ptr_q  <= rd_ptr_q + 1'b1;
        pkt_cnt_q <= end_q ? '0 : pkt_cnt_q + 1'b1;
      end

      case ({push, pop})
        2'b10:   level_q <= level_q + ONE_LEVEL;
        2'b01:   level_q <= level_q - ONE_LEVEL;
        default: level_q <= level_q;
      endcase
    end
  end

  assign head_rec = queue[rd_ptr_q];

  always_comb begin
    t_valid_o     = (level_q != '0);
    t_data_o.data = head_rec.octet[byte_idx_q];  // seq goes out first
    t_data_o.keep = 1'b1;
    t_data_o.last = end_q && (byte_idx_q == 2'd3);
  end

  assign level_o = level_q;

  a_level_bound: assert property (
    @(posedge clock) disable iff (!areset_n)
    level_o <= FULL_LEVEL
  );

endmodule

// File: rtl/usb_bridge_macros.svh
`ifndef USB_BRIDGE_MACROS_SVH
`define USB_BRIDGE_MACROS_SVH

// Byte lane of every stream
`define USB_DATA_W 8

// Telemetry record queue, in records
`define TELEM_DEPTH 16

// Records per telemetry packet before tlast is forced
`define TELEM_PKT_RECS 4

// Bulk-IN endpoint that is served from the telemetry queue
`define TELEM_ENDPT 2

// Flops in the reset release chain
`define RESET_STAGES 4

`endif

// File: rtl/usb_bridge_pkg.sv
`include "usb_bridge_macros.svh"

package usb_bridge_pkg;

  // One stream beat
  typedef struct packed {
    logic [`USB_DATA_W-1:0] data;
    logic                   keep;
    logic                   last;
  } axis_byte_t;

  // Link status as reported by the protocol cores
  typedef struct packed {
    logic       crc_error;
    logic       timeout;
    logic [3:0] phy_state;
    logic [2:0] usb_error;
  } link_status_t;

  // Field view of a telemetry record, seq sits in the low byte
  typedef struct packed {
    logic [14:0]  rsvd;    // Always zero
    link_status_t status;
    logic [7:0]   seq;
  } telem_fields_t;

  // Same record, seen as the bytes that go out on the stream
  typedef union packed {
    telem_fields_t                   fields;
    logic [3:0][`USB_DATA_W-1:0]     octet;
  } telem_rec_u;

  // Queued record count, 0 up to a full queue
  typedef logic [$clog2(`TELEM_DEPTH+1)-1:0] telem_level_t;

endpackage

// File: vlog.f
+incdir+rtl
rtl/usb_bridge_pkg.sv
rtl/link_reset_ctrl.sv
rtl/telemetry_capture.sv
rtl/in_path_mux.sv
rtl/axis_skid.sv
rtl/bulk_in_bridge.sv
dv/bulk_in_bridge_tb.sv
